// File: hdl/clock_pkg.sv
// Mode, position and range constants, divider defaults, digit to segment decoder
`default_nettype none

package clock_pkg;

	// ----------------------------------------
	// Operating modes, stepped by the mode button
	// ----------------------------------------
	localparam int MODE_W = 2;
	localparam logic [MODE_W-1:0] MODE_RUN   = 2'd0;
	localparam logic [MODE_W-1:0] MODE_SET   = 2'd1;
	localparam logic [MODE_W-1:0] MODE_ALARM = 2'd2;

	// Field selected for setting
	localparam int POS_W = 2;
	localparam logic [POS_W-1:0] POS_SEC = 2'd0;
	localparam logic [POS_W-1:0] POS_MIN = 2'd1;
	localparam logic [POS_W-1:0] POS_HOU = 2'd2;

	// ----------------------------------------
	// Time fields and display
	// ----------------------------------------
	localparam int FIELD_W = 6;
	localparam logic [FIELD_W-1:0] SEC_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] MIN_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] HOU_MAX = 6'd23;

	localparam int DIGITS = 6;
	localparam int SEG_W  = 7;

	localparam logic [31:0] CLKS_PER_SEC_DEF  = 32'd50_000_000;	// 50 MHz board clock
	localparam logic [31:0] CLKS_PER_SCAN_DEF = 32'd5_000;		// One digit slot

	// Segments a..g from MSB down, active high
	function automatic logic [SEG_W-1:0] digit_to_seg(input logic [3:0] digit);
		case (digit)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;	// Dark for non-decimal codes
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hdl/digital_clock_top.sv
// Digital clock top level with panel, tick, timekeeping and display blocks
`default_nettype none

module digital_clock_top #(
	parameter logic [31:0] CLKS_PER_SEC  = clock_pkg::CLKS_PER_SEC_DEF,
	parameter logic [31:0] CLKS_PER_SCAN = clock_pkg::CLKS_PER_SCAN_DEF
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          i_btn_mode,
	input  wire                          i_btn_pos,
	input  wire                          i_btn_inc,
	input  wire                          i_btn_alarm,
	output logic [clock_pkg::SEG_W-1:0]  o_seg,
	output logic [clock_pkg::DIGITS-1:0] o_seg_enb,
	output logic                         o_seg_dp,
	output logic                         o_alarm
);

	logic [clock_pkg::MODE_W-1:0]  mode;
	logic [clock_pkg::POS_W-1:0]   pos;
	logic                          alarm_en;
	logic                          inc_stb;
	logic                          sec_stb;
	logic                          scan_stb;
	logic                          blink_on;
	logic [clock_pkg::FIELD_W-1:0] sec;
	logic [clock_pkg::FIELD_W-1:0] min;
	logic [clock_pkg::FIELD_W-1:0] hou;
	logic [clock_pkg::FIELD_W-1:0] alm_sec;
	logic [clock_pkg::FIELD_W-1:0] alm_min;
	logic [clock_pkg::FIELD_W-1:0] alm_hou;
	logic                          alarm;

	// ----------------------------------------
	// Input side
	// ----------------------------------------
	panel_ctrl panel_ctrl_i (
		.clk(clk), .rst_n(rst_n),
		.i_btn_mode(i_btn_mode), .i_btn_pos(i_btn_pos),
		.i_btn_inc(i_btn_inc), .i_btn_alarm(i_btn_alarm),
		.o_mode(mode), .o_pos(pos), .o_alarm_en(alarm_en), .o_inc_stb(inc_stb)
	);

	tick_gen #(.CLKS_PER_SEC(CLKS_PER_SEC), .CLKS_PER_SCAN(CLKS_PER_SCAN)) tick_gen_i (
		.clk(clk), .rst_n(rst_n),
		.o_sec_stb(sec_stb), .o_scan_stb(scan_stb), .o_blink_on(blink_on)
	);

	time_keeper time_keeper_i (
		.clk(clk), .rst_n(rst_n),
		.i_mode(mode), .i_pos(pos), .i_alarm_en(alarm_en),
		.i_sec_stb(sec_stb), .i_inc_stb(inc_stb),
		.o_sec(sec), .o_min(min), .o_hou(hou),
		.o_alm_sec(alm_sec), .o_alm_min(alm_min), .o_alm_hou(alm_hou),
		.o_alarm(alarm)
	);

	// ----------------------------------------
	// Output side
	// ----------------------------------------
	display_scan display_scan_i (
		.clk(clk), .rst_n(rst_n),
		.i_mode(mode), .i_pos(pos), .i_alarm(alarm),
		.i_scan_stb(scan_stb), .i_blink_on(blink_on),
		.i_sec(sec), .i_min(min), .i_hou(hou),
		.i_alm_sec(alm_sec), .i_alm_min(alm_min), .i_alm_hou(alm_hou),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb), .o_seg_dp(o_seg_dp)
	);

	assign o_alarm = alarm;	// Plain level, no buzzer

endmodule

`default_nettype wire

// File: hdl/display_scan.sv
// Digit scan, decimal split, blanking, segment and point drive
`default_nettype none

module display_scan (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire  [clock_pkg::MODE_W-1:0]  i_mode,
	input  wire  [clock_pkg::POS_W-1:0]   i_pos,
	input  wire                           i_alarm,
	input  wire                           i_scan_stb,
	input  wire                           i_blink_on,
	input  wire  [clock_pkg::FIELD_W-1:0] i_sec,
	input  wire  [clock_pkg::FIELD_W-1:0] i_min,
	input  wire  [clock_pkg::FIELD_W-1:0] i_hou,
	input  wire  [clock_pkg::FIELD_W-1:0] i_alm_sec,
	input  wire  [clock_pkg::FIELD_W-1:0] i_alm_min,
	input  wire  [clock_pkg::FIELD_W-1:0] i_alm_hou,
	output logic [clock_pkg::SEG_W-1:0]   o_seg,
	output logic [clock_pkg::DIGITS-1:0]  o_seg_enb,
	output logic                          o_seg_dp
);

	logic [$clog2(clock_pkg::DIGITS)-1:0] idx;	// Digit currently driven
	logic [clock_pkg::FIELD_W-1:0]        field;
	logic [3:0]                           digit;
	logic                                 setting;
	logic                                 sel_field;
	logic                                 blank;
	logic [clock_pkg::DIGITS-1:0]         enb_hot;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx <= '0;
		else if (i_scan_stb)
			idx <= (idx == ($clog2(clock_pkg::DIGITS))'(clock_pkg::DIGITS - 1)) ? '0 : idx + 1'b1;
	end

	// ----------------------------------------
	// Field and digit for the current slot
	// ----------------------------------------
	always_comb begin
		case (idx[2:1])
			2'd0:    field = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_sec : i_sec;
			2'd1:    field = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_min : i_min;
			default: field = (i_mode == clock_pkg::MODE_ALARM) ? i_alm_hou : i_hou;
		endcase
	end

	// Even slot ones, odd slot tens
	assign digit = idx[0] ? 4'(field / 6'd10) : 4'(field % 6'd10);

	assign setting   = (i_mode == clock_pkg::MODE_SET) || (i_mode == clock_pkg::MODE_ALARM);
	assign sel_field = (idx[2:1] == i_pos);
	assign blank     = setting && sel_field && !i_blink_on;	// Selected field flashes

	assign o_seg = blank ? '0 : clock_pkg::digit_to_seg(digit);

	// Ones point while setting time, tens point while setting alarm
	assign o_seg_dp = i_alarm ||
		(i_mode == clock_pkg::MODE_SET && sel_field && !idx[0]) ||
		(i_mode == clock_pkg::MODE_ALARM && sel_field && idx[0]);

	assign enb_hot   = {{(clock_pkg::DIGITS - 1){1'b0}}, 1'b1} << idx;
	assign o_seg_enb = ~enb_hot;	// Common node is active low

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

`default_nettype wire

// File: hdl/panel_ctrl.sv
// Button synchronizers, edge events, mode, position and alarm-enable registers
`default_nettype none

module panel_ctrl (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          i_btn_mode,
	input  wire                          i_btn_pos,
	input  wire                          i_btn_inc,
	input  wire                          i_btn_alarm,
	output logic [clock_pkg::MODE_W-1:0] o_mode,
	output logic [clock_pkg::POS_W-1:0]  o_pos,
	output logic                         o_alarm_en,
	output logic                         o_inc_stb
);

	// Bit order: alarm, inc, pos, mode
	logic [3:0] sync1;
	logic [3:0] sync2;
	logic [3:0] btn_dly;	// Previous synchronized level
	logic [3:0] btn_evt;

	// ----------------------------------------
	// Synchronizer and edge detect
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1   <= '0;
			sync2   <= '0;
			btn_dly <= '0;
		end else begin
			sync1   <= {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};
			sync2   <= sync1;
			btn_dly <= sync2;
		end
	end

	assign btn_evt = sync2 & ~btn_dly;	// One cycle per press

	// ----------------------------------------
	// Panel state
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_RUN;
			o_pos      <= clock_pkg::POS_SEC;
			o_alarm_en <= 1'b0;
			o_inc_stb  <= 1'b0;
		end else begin
			if (btn_evt[0]) begin
				if (o_mode >= clock_pkg::MODE_ALARM)
					o_mode <= clock_pkg::MODE_RUN;
				else
					o_mode <= o_mode + 1'b1;
			end
			if (btn_evt[1]) begin
				if (o_pos >= clock_pkg::POS_HOU)
					o_pos <= clock_pkg::POS_SEC;
				else
					o_pos <= o_pos + 1'b1;
			end
			if (btn_evt[3])
				o_alarm_en <= ~o_alarm_en;
			// Increment only matters while setting
			o_inc_stb <= btn_evt[2] &&
				(o_mode == clock_pkg::MODE_SET || o_mode == clock_pkg::MODE_ALARM);
		end
	end

	// A held increment button must not repeat
	a_inc_single: assert property (@(posedge clk) disable iff (!rst_n)
		o_inc_stb |=> !o_inc_stb);

endmodule

`default_nettype wire

// File: hdl/tick_gen.sv
// Second strobe, digit scan strobe and blink phase from free-running counters
`default_nettype none

module tick_gen #(
	parameter logic [31:0] CLKS_PER_SEC  = clock_pkg::CLKS_PER_SEC_DEF,
	parameter logic [31:0] CLKS_PER_SCAN = clock_pkg::CLKS_PER_SCAN_DEF
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_sec_stb,
	output logic o_scan_stb,
	output logic o_blink_on
);

	logic [31:0] sec_cnt;
	logic [31:0] scan_cnt;

	assign o_sec_stb  = (sec_cnt == CLKS_PER_SEC - 32'd1);
	assign o_scan_stb = (scan_cnt == CLKS_PER_SCAN - 32'd1);
	assign o_blink_on = (sec_cnt < (CLKS_PER_SEC >> 1));	// First half of the second

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt  <= '0;
			scan_cnt <= '0;
		end else begin
			sec_cnt  <= o_sec_stb ? 32'd0 : sec_cnt + 32'd1;
			scan_cnt <= o_scan_stb ? 32'd0 : scan_cnt + 32'd1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/time_keeper.sv
// Running and alarm time registers, setting increments, alarm match flag
`default_nettype none

module time_keeper (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire  [clock_pkg::MODE_W-1:0]  i_mode,
	input  wire  [clock_pkg::POS_W-1:0]   i_pos,
	input  wire                           i_alarm_en,
	input  wire                           i_sec_stb,
	input  wire                           i_inc_stb,
	output logic [clock_pkg::FIELD_W-1:0] o_sec,
	output logic [clock_pkg::FIELD_W-1:0] o_min,
	output logic [clock_pkg::FIELD_W-1:0] o_hou,
	output logic [clock_pkg::FIELD_W-1:0] o_alm_sec,
	output logic [clock_pkg::FIELD_W-1:0] o_alm_min,
	output logic [clock_pkg::FIELD_W-1:0] o_alm_hou,
	output logic                          o_alarm
);

	logic time_match;

	function automatic logic [clock_pkg::FIELD_W-1:0] wrap_inc(
		input logic [clock_pkg::FIELD_W-1:0] val,
		input logic [clock_pkg::FIELD_W-1:0] last
	);
		return (val >= last) ? '0 : val + 1'b1;
	endfunction

	// ----------------------------------------
	// Running time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hou <= '0;
		end else if (i_mode == clock_pkg::MODE_SET) begin
			if (i_inc_stb) begin	// Frozen, no carry between fields
				case (i_pos)
					clock_pkg::POS_SEC: o_sec <= wrap_inc(o_sec, clock_pkg::SEC_MAX);
					clock_pkg::POS_MIN: o_min <= wrap_inc(o_min, clock_pkg::MIN_MAX);
					clock_pkg::POS_HOU: o_hou <= wrap_inc(o_hou, clock_pkg::HOU_MAX);
					default: ;
				endcase
			end
		end else if (i_sec_stb) begin
			o_sec <= wrap_inc(o_sec, clock_pkg::SEC_MAX);
			if (o_sec == clock_pkg::SEC_MAX) begin
				o_min <= wrap_inc(o_min, clock_pkg::MIN_MAX);
				if (o_min == clock_pkg::MIN_MAX)
					o_hou <= wrap_inc(o_hou, clock_pkg::HOU_MAX);
			end
		end
	end

	// ----------------------------------------
	// Alarm time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alm_sec <= '0;
			o_alm_min <= '0;
			o_alm_hou <= '0;
		end else if (i_mode == clock_pkg::MODE_ALARM && i_inc_stb) begin
			case (i_pos)
				clock_pkg::POS_SEC: o_alm_sec <= wrap_inc(o_alm_sec, clock_pkg::SEC_MAX);
				clock_pkg::POS_MIN: o_alm_min <= wrap_inc(o_alm_min, clock_pkg::MIN_MAX);
				clock_pkg::POS_HOU: o_alm_hou <= wrap_inc(o_alm_hou, clock_pkg::HOU_MAX);
				default: ;
			endcase
		end
	end

	assign time_match = (o_sec == o_alm_sec) && (o_min == o_alm_min) && (o_hou == o_alm_hou);

	// Latches on match, cleared only by disabling
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en & (time_match | o_alarm);
	end

	a_field_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_sec <= clock_pkg::SEC_MAX && o_min <= clock_pkg::MIN_MAX &&
		o_hou <= clock_pkg::HOU_MAX && o_alm_sec <= clock_pkg::SEC_MAX &&
		o_alm_min <= clock_pkg::MIN_MAX && o_alm_hou <= clock_pkg::HOU_MAX);

endmodule

`default_nettype wire

// File: project.f
hdl/clock_pkg.sv
hdl/panel_ctrl.sv
hdl/tick_gen.sv
hdl/time_keeper.sv
hdl/display_scan.sv
hdl/digital_clock_top.sv
testbench/tb_digital_clock.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the digital clock testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_digital_clock -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "Simulation failed"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
echo "Simulation passed"
exit 0

// File: testbench/tb_digital_clock.sv
// Digital clock testbench with time model, display decoder, checking assertions and watchdog
`default_nettype none

module tb_digital_clock;

	localparam int PERIOD    = 40;
	localparam int CPS       = 60;	// Cycles per second
	localparam int CPSCAN    = 2;	// Cycles per digit slot
	localparam int TEST_SECS = 62 + 10 + 34 + 10;	// Run, set, alarm, margin
	localparam int LIMIT_CYCLES = TEST_SECS * CPS + 5;

	localparam logic [3:0] BTN_MODE  = 4'b0001;
	localparam logic [3:0] BTN_POS   = 4'b0010;
	localparam logic [3:0] BTN_INC   = 4'b0100;
	localparam logic [3:0] BTN_ALARM = 4'b1000;

	logic       clk;
	logic       rst_n;
	logic [3:0] btn;	// alarm, inc, pos, mode
	logic [6:0] o_seg;
	logic [5:0] o_seg_enb;
	logic       o_seg_dp;
	logic       o_alarm;
	integer     seed;

	// Model state
	int         phase;
	int         scan_cnt;
	logic [2:0] scan_idx;
	logic [1:0] m_mode;
	logic [1:0] m_pos;
	logic       m_alarm_en;
	logic       inc_req;
	logic [5:0] m_sec, m_min, m_hou;
	logic [5:0] m_asec, m_amin, m_ahou;
	logic       m_alarm;

	logic [5:0] slot_field;
	logic       blank;
	logic [3:0] exp_digit;
	logic [3:0] shown_digit;
	logic       exp_dp;
	logic [5:0] exp_enb;

	digital_clock_top #(.CLKS_PER_SEC(CPS), .CLKS_PER_SCAN(CPSCAN)) dut_i (
		.clk(clk), .rst_n(rst_n),
		.i_btn_mode(btn[0]), .i_btn_pos(btn[1]), .i_btn_inc(btn[2]), .i_btn_alarm(btn[3]),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb), .o_seg_dp(o_seg_dp), .o_alarm(o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Segments a..g, MSB first; 4'hF marks a dark digit
	function automatic logic [3:0] seg_to_digit(input logic [6:0] seg);
		case (seg)
			7'b111_1110: return 4'd0;
			7'b011_0000: return 4'd1;
			7'b110_1101: return 4'd2;
			7'b111_1001: return 4'd3;
			7'b011_0011: return 4'd4;
			7'b101_1011: return 4'd5;
			7'b101_1111: return 4'd6;
			7'b111_0000: return 4'd7;
			7'b111_1111: return 4'd8;
			7'b111_0011: return 4'd9;
			7'b000_0000: return 4'hF;
			default:     return 4'hE;	// Garbage pattern
		endcase
	endfunction

	function automatic logic [5:0] wrap_next(input logic [5:0] v, input int modulus);
		return 6'((int'(v) + 1) % modulus);
	endfunction

	// ----------------------------------------
	// Reference model of time, scan and alarm
	// ----------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase    <= 0;
			scan_cnt <= 0;
			scan_idx <= 3'd0;
			{m_sec, m_min, m_hou}    <= '0;
			{m_asec, m_amin, m_ahou} <= '0;
			m_alarm  <= 1'b0;
		end else begin
			phase <= (phase == CPS - 1) ? 0 : phase + 1;
			if (scan_cnt == CPSCAN - 1) begin
				scan_cnt <= 0;
				scan_idx <= (scan_idx == 3'd5) ? 3'd0 : scan_idx + 3'd1;
			end else begin
				scan_cnt <= scan_cnt + 1;
			end
			if (m_mode == clock_pkg::MODE_SET) begin
				if (inc_req) begin	// No carry while setting
					case (m_pos)
						clock_pkg::POS_SEC: m_sec <= wrap_next(m_sec, 60);
						clock_pkg::POS_MIN: m_min <= wrap_next(m_min, 60);
						default:            m_hou <= wrap_next(m_hou, 24);
					endcase
				end
			end else if (phase == CPS - 1) begin
				m_sec <= wrap_next(m_sec, 60);
				if (m_sec == 6'd59) begin
					m_min <= wrap_next(m_min, 60);
					if (m_min == 6'd59)
						m_hou <= wrap_next(m_hou, 24);
				end
			end
			if (m_mode == clock_pkg::MODE_ALARM && inc_req) begin
				case (m_pos)
					clock_pkg::POS_SEC: m_asec <= wrap_next(m_asec, 60);
					clock_pkg::POS_MIN: m_amin <= wrap_next(m_amin, 60);
					default:            m_ahou <= wrap_next(m_ahou, 24);
				endcase
			end
			m_alarm <= m_alarm_en &&
				(m_alarm || (m_sec == m_asec && m_min == m_amin && m_hou == m_ahou));
		end
	end

	// Expected digit, point and enable for the slot being scanned
	always_comb begin
		case (scan_idx[2:1])
			2'd0:    slot_field = (m_mode == clock_pkg::MODE_ALARM) ? m_asec : m_sec;
			2'd1:    slot_field = (m_mode == clock_pkg::MODE_ALARM) ? m_amin : m_min;
			default: slot_field = (m_mode == clock_pkg::MODE_ALARM) ? m_ahou : m_hou;
		endcase
		blank = (m_mode != clock_pkg::MODE_RUN) && (scan_idx[2:1] == m_pos) &&
			(phase >= CPS / 2);
		if (blank)
			exp_digit = 4'hF;
		else if (scan_idx[0])
			exp_digit = 4'(slot_field / 6'd10);
		else
			exp_digit = 4'(slot_field % 6'd10);
		exp_dp = m_alarm || (scan_idx[2:1] == m_pos &&
			((m_mode == clock_pkg::MODE_SET && !scan_idx[0]) ||
			(m_mode == clock_pkg::MODE_ALARM && scan_idx[0])));
	end

	assign exp_enb     = ~(6'd1 << scan_idx);
	assign shown_digit = seg_to_digit(o_seg);

	task automatic fail_and_stop();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on first error");
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	a_scan: assert property (@(posedge clk) disable iff (!rst_n) o_seg_enb == exp_enb)
		else begin
			$display("Error: o_seg_enb expected %h got %h", $sampled(exp_enb), $sampled(o_seg_enb));
			fail_and_stop();
		end

	// Two cycles after a tick are left out
	a_digit: assert property (@(posedge clk) disable iff (!rst_n)
		(phase > 1) |-> (shown_digit == exp_digit))
		else begin
			$display("Error: o_seg digit expected %h got %h (o_seg %h)",
				$sampled(exp_digit), $sampled(shown_digit), $sampled(o_seg));
			fail_and_stop();
		end

	a_point: assert property (@(posedge clk) disable iff (!rst_n) o_seg_dp == exp_dp)
		else begin
			$display("Error: o_seg_dp expected %h got %h", $sampled(exp_dp), $sampled(o_seg_dp));
			fail_and_stop();
		end

	a_alarm: assert property (@(posedge clk) disable iff (!rst_n) o_alarm == m_alarm)
		else begin
			$display("Error: o_alarm expected %h got %h", $sampled(m_alarm), $sampled(o_alarm));
			fail_and_stop();
		end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	// 4 cycles high, 4 low; the panel reacts on the third edge after the press
	task automatic press_button(input logic [3:0] mask);
		@(posedge clk);
		btn <= mask;
		repeat (3) @(posedge clk);
		if (mask == BTN_MODE)
			m_mode <= (m_mode == clock_pkg::MODE_ALARM) ? clock_pkg::MODE_RUN : m_mode + 2'd1;
		if (mask == BTN_POS)
			m_pos <= (m_pos == clock_pkg::POS_HOU) ? clock_pkg::POS_SEC : m_pos + 2'd1;
		if (mask == BTN_ALARM)
			m_alarm_en <= ~m_alarm_en;
		if (mask == BTN_INC && m_mode != clock_pkg::MODE_RUN)
			inc_req <= 1'b1;
		@(posedge clk);
		inc_req <= 1'b0;
		btn     <= 4'b0000;
		repeat (3) @(posedge clk);
	endtask

	task automatic repeat_presses(input logic [3:0] mask, input int count);
		repeat (count) press_button(mask);
	endtask

	initial begin
		int n_sec;
		int n_min;
		int now_s;
		int tgt;
		seed       = 32'hd634_f9cc;
		rst_n      <= 1'b0;
		btn        <= 4'b0000;
		m_mode     <= clock_pkg::MODE_RUN;
		m_pos      <= clock_pkg::POS_SEC;
		m_alarm_en <= 1'b0;
		inc_req    <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		repeat (62 * CPS) @(posedge clk);	// Through a minute carry

		// Time setting, hours wrap after 25 steps
		press_button(BTN_MODE);
		n_sec = $unsigned($random(seed)) % 11 + 1;
		n_min = $unsigned($random(seed)) % 11 + 1;
		repeat_presses(BTN_INC, n_sec);
		press_button(BTN_POS);
		repeat_presses(BTN_INC, n_min);
		press_button(BTN_POS);
		repeat_presses(BTN_INC, 25);
		repeat (2 * CPS) @(posedge clk);	// Both blink halves

		// Alarm 30 s ahead, enough for all the presses
		press_button(BTN_MODE);
		now_s = int'(m_hou) * 3600 + int'(m_min) * 60 + int'(m_sec);
		tgt   = (now_s + 30) % 86400;
		repeat_presses(BTN_INC, (tgt / 3600 - int'(m_ahou) + 24) % 24);
		press_button(BTN_POS);
		repeat_presses(BTN_INC, (tgt % 60 - int'(m_asec) + 60) % 60);
		press_button(BTN_POS);
		repeat_presses(BTN_INC, ((tgt / 60) % 60 - int'(m_amin) + 60) % 60);
		press_button(BTN_ALARM);
		while (!o_alarm)
			@(posedge clk);
		repeat (CPS) @(posedge clk);
		press_button(BTN_ALARM);	// Disable drops the alarm
		repeat (20) @(posedge clk);

		$display("NO ERRORS");
		$finish;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timeout: the test sequence did not finish within %0d cycles", LIMIT_CYCLES);
		fail_and_stop();
	end

endmodule

`default_nettype wire
